//--- source/mem_hier_pkg.sv
package mem_hier_pkg;

    // cacheline geometry
    localparam int unsigned line_bits_p   = 256;
    localparam int unsigned line_bytes_p  = 32;

    // burst memory side, four beats per line
    localparam int unsigned beat_bits_p   = 64;
    localparam int unsigned beats_p       = 4;

    // byte offset inside a line
    localparam int unsigned offset_bits_p = 5;

    // arbiter states
    // a store walks through data_rd, data_merge and data_wr
    typedef enum logic [2:0] {
        arb_idle,
        arb_fetch_rd,
        arb_data_rd,
        arb_data_merge,
        arb_data_wr,
        arb_done
    } arb_state_e;

    // cacheline adaptor states
    typedef enum logic [1:0] {
        cla_idle,
        cla_rd_burst,
        cla_wr_burst,
        cla_resp
    } cla_state_e;

endpackage : mem_hier_pkg

//--- source/mem_word_adapter.sv
module mem_word_adapter
    import mem_hier_pkg::*;
(
    // word side
    input  logic [31:0]               mem_address_i,
    input  logic [31:0]               mem_wdata_i,
    input  logic [3:0]                mem_byte_enable_i,
    output logic [31:0]               mem_rdata_o,

    // line side
    input  logic [line_bits_p-1:0]    line_rdata_i,
    output logic [31:0]               line_address_o,
    output logic [line_bits_p-1:0]    line_wdata_o,
    output logic [line_bytes_p-1:0]   line_byte_enable_o
);

    // word lane inside the line, address bits 4 to 2
    logic [2:0] word_sel;

    assign word_sel = mem_address_i[offset_bits_p-1:2];

    // line aligned address, offset bits cleared
    assign line_address_o = {mem_address_i[31:offset_bits_p], {offset_bits_p{1'b0}}};

    // same word in every lane
    // only the enabled bytes get merged downstream
    assign line_wdata_o = {(line_bits_p / 32){mem_wdata_i}};

    // move the 4-bit mask to the lane of this word
    always_comb begin
        line_byte_enable_o = {{(line_bytes_p - 4){1'b0}}, mem_byte_enable_i}
                             << {word_sel, 2'b00};
    end

    // pick the addressed word out of the returned line
    assign mem_rdata_o = line_rdata_i[{word_sel, 5'b00000} +: 32];

endmodule : mem_word_adapter

//--- source/mem_arbiter.sv
module mem_arbiter
    import mem_hier_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,

    // fetch port, read only
    input  logic [31:0]               fetch_address_i,
    input  logic                      fetch_read_i,
    output logic [line_bits_p-1:0]    fetch_rdata_o,
    output logic                      fetch_resp_o,

    // data port
    input  logic [31:0]               data_address_i,
    input  logic                      data_read_i,
    input  logic                      data_write_i,
    input  logic [line_bits_p-1:0]    data_wdata_i,
    input  logic [line_bytes_p-1:0]   data_byte_enable_i,
    output logic [line_bits_p-1:0]    data_rdata_o,
    output logic                      data_resp_o,

    // toward the cacheline adaptor
    output logic [31:0]               line_address_o,
    output logic                      line_read_o,
    output logic                      line_write_o,
    output logic [line_bits_p-1:0]    line_wdata_o,
    input  logic [line_bits_p-1:0]    line_rdata_i,
    input  logic                      line_resp_i
);

    arb_state_e               state_q;
    arb_state_e               state_d;
    logic                     serve_data_q;
    logic                     serve_data_d;
    logic [line_bits_p-1:0]   line_q;
    logic [line_bits_p-1:0]   merged_line;

    // enabled store bytes over the fetched line
    always_comb begin
        merged_line = line_q;
        for (int i = 0; i < line_bytes_p; i++) begin
            if (data_byte_enable_i[i]) begin
                merged_line[8*i +: 8] = data_wdata_i[8*i +: 8];
            end
        end
    end

    always_comb begin
        state_d      = state_q;
        serve_data_d = serve_data_q;
        case (state_q)
            arb_idle: begin
                // data port wins a tie
                if (data_read_i || data_write_i) begin
                    state_d      = arb_data_rd;
                    serve_data_d = 1'b1;
                end else if (fetch_read_i) begin
                    state_d      = arb_fetch_rd;
                    serve_data_d = 1'b0;
                end
            end
            arb_fetch_rd: if (line_resp_i) state_d = arb_done;
            arb_data_rd: begin
                if (line_resp_i) begin
                    state_d = data_write_i ? arb_data_merge : arb_done;
                end
            end
            arb_data_merge: state_d = arb_data_wr;
            arb_data_wr: if (line_resp_i) state_d = arb_done;
            arb_done: state_d = arb_idle;
            default: state_d = arb_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= arb_idle;
            serve_data_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            serve_data_q <= serve_data_d;
        end
    end

    // returned line, later the merged line for a store
    always_ff @(posedge clk) begin
        if ((state_q == arb_fetch_rd || state_q == arb_data_rd) && line_resp_i) begin
            line_q <= line_rdata_i;
        end else if (state_q == arb_data_merge) begin
            line_q <= merged_line;
        end
    end

    // port addresses are held stable until resp
    assign line_address_o = serve_data_q ? data_address_i : fetch_address_i;
    assign line_read_o    = (state_q == arb_fetch_rd) || (state_q == arb_data_rd);
    assign line_write_o   = (state_q == arb_data_wr);
    assign line_wdata_o   = line_q;

    assign fetch_rdata_o  = line_q;
    assign data_rdata_o   = line_q;
    assign fetch_resp_o   = (state_q == arb_done) && !serve_data_q;
    assign data_resp_o    = (state_q == arb_done) && serve_data_q;

endmodule : mem_arbiter

//--- source/cacheline_adaptor.sv
module cacheline_adaptor
    import mem_hier_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,

    // line side
    input  logic [line_bits_p-1:0]    line_wdata_i,
    input  logic [31:0]               line_address_i,
    input  logic                      line_read_i,
    input  logic                      line_write_i,
    output logic [line_bits_p-1:0]    line_rdata_o,
    output logic                      line_resp_o,

    // burst memory pins
    input  logic [beat_bits_p-1:0]    bmem_rdata_i,
    input  logic                      bmem_resp_i,
    output logic [31:0]               bmem_address_o,
    output logic                      bmem_read_o,
    output logic                      bmem_write_o,
    output logic [beat_bits_p-1:0]    bmem_wdata_o
);

    cla_state_e               state_q;
    logic [1:0]               beat_cnt;
    logic [line_bits_p-1:0]   line_q;
    logic [31:0]              address_q;
    logic                     last_beat;

    assign last_beat = bmem_resp_i && (beat_cnt == 2'(beats_p - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= cla_idle;
            beat_cnt <= 2'd0;
        end else begin
            case (state_q)
                cla_idle: begin
                    beat_cnt <= 2'd0;
                    if (line_read_i) begin
                        state_q <= cla_rd_burst;
                    end else if (line_write_i) begin
                        state_q <= cla_wr_burst;
                    end
                end
                cla_rd_burst, cla_wr_burst: begin
                    if (bmem_resp_i) beat_cnt <= beat_cnt + 2'd1;
                    if (last_beat) state_q <= cla_resp;
                end
                cla_resp: state_q <= cla_idle;
                default: state_q <= cla_idle;
            endcase
        end
    end

    // line buffer and address
    // beats shift in from the top so beat 0 ends up in bits 63 to 0
    always_ff @(posedge clk) begin
        if (state_q == cla_idle) begin
            address_q <= line_address_i;
            if (line_write_i) line_q <= line_wdata_i;
        end else if (state_q == cla_rd_burst && bmem_resp_i) begin
            line_q <= {bmem_rdata_i, line_q[line_bits_p-1:beat_bits_p]};
        end
    end

    assign bmem_address_o = address_q;
    assign bmem_read_o    = (state_q == cla_rd_burst);
    assign bmem_write_o   = (state_q == cla_wr_burst);
    assign bmem_wdata_o   = line_q[{beat_cnt, 6'b000000} +: beat_bits_p];

    assign line_rdata_o   = line_q;
    assign line_resp_o    = (state_q == cla_resp);

endmodule : cacheline_adaptor

//--- source/mem_hier_top.sv
module mem_hier_top
    import mem_hier_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,

    // instruction fetch port
    input  logic [31:0]               imem_address_i,
    input  logic                      imem_read_i,
    output logic [31:0]               imem_rdata_o,
    output logic                      imem_resp_o,

    // data port
    input  logic [31:0]               dmem_address_i,
    input  logic                      dmem_read_i,
    input  logic                      dmem_write_i,
    input  logic [3:0]                dmem_wmask_i,
    input  logic [31:0]               dmem_wdata_i,
    output logic [31:0]               dmem_rdata_o,
    output logic                      dmem_resp_o,

    // burst memory
    output logic [31:0]               bmem_address_o,
    output logic                      bmem_read_o,
    output logic                      bmem_write_o,
    input  logic [beat_bits_p-1:0]    bmem_rdata_i,
    output logic [beat_bits_p-1:0]    bmem_wdata_o,
    input  logic                      bmem_resp_i
);

    // word adapters to arbiter
    logic [31:0]               imem_line_address;
    logic [line_bits_p-1:0]    imem_line_rdata;
    logic [31:0]               dmem_line_address;
    logic [line_bits_p-1:0]    dmem_line_rdata;
    logic [line_bits_p-1:0]    dmem_line_wdata;
    logic [line_bytes_p-1:0]   dmem_line_byte_enable;

    // arbiter to cacheline adaptor
    logic [31:0]               line_address;
    logic                      line_read;
    logic                      line_write;
    logic [line_bits_p-1:0]    line_wdata;
    logic [line_bits_p-1:0]    line_rdata;
    logic                      line_resp;

    // fetch side never writes
    mem_word_adapter imem_word_adapter (
        .mem_address_i      (imem_address_i),
        .mem_wdata_i        (32'd0),
        .mem_byte_enable_i  (4'd0),
        .mem_rdata_o        (imem_rdata_o),
        .line_rdata_i       (imem_line_rdata),
        .line_address_o     (imem_line_address),
        .line_wdata_o       (),
        .line_byte_enable_o ()
    );

    mem_word_adapter dmem_word_adapter (
        .mem_address_i      (dmem_address_i),
        .mem_wdata_i        (dmem_wdata_i),
        .mem_byte_enable_i  (dmem_wmask_i),
        .mem_rdata_o        (dmem_rdata_o),
        .line_rdata_i       (dmem_line_rdata),
        .line_address_o     (dmem_line_address),
        .line_wdata_o       (dmem_line_wdata),
        .line_byte_enable_o (dmem_line_byte_enable)
    );

    mem_arbiter mem_arbiter (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .fetch_address_i    (imem_line_address),
        .fetch_read_i       (imem_read_i),
        .fetch_rdata_o      (imem_line_rdata),
        .fetch_resp_o       (imem_resp_o),
        .data_address_i     (dmem_line_address),
        .data_read_i        (dmem_read_i),
        .data_write_i       (dmem_write_i),
        .data_wdata_i       (dmem_line_wdata),
        .data_byte_enable_i (dmem_line_byte_enable),
        .data_rdata_o       (dmem_line_rdata),
        .data_resp_o        (dmem_resp_o),
        .line_address_o     (line_address),
        .line_read_o        (line_read),
        .line_write_o       (line_write),
        .line_wdata_o       (line_wdata),
        .line_rdata_i       (line_rdata),
        .line_resp_i        (line_resp)
    );

    cacheline_adaptor cacheline_adaptor (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .line_wdata_i       (line_wdata),
        .line_address_i     (line_address),
        .line_read_i        (line_read),
        .line_write_i       (line_write),
        .line_rdata_o       (line_rdata),
        .line_resp_o        (line_resp),
        .bmem_rdata_i       (bmem_rdata_i),
        .bmem_resp_i        (bmem_resp_i),
        .bmem_address_o     (bmem_address_o),
        .bmem_read_o        (bmem_read_o),
        .bmem_write_o       (bmem_write_o),
        .bmem_wdata_o       (bmem_wdata_o)
    );

endmodule : mem_hier_top

//--- bench/burst_mem_model.sv
module burst_mem_model (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [31:0] address_i,
    input  logic        read_i,
    input  logic        write_i,
    input  logic [63:0] wdata_i,
    output logic [63:0] rdata_o,
    output logic        resp_o
);

    localparam int latency_c = 3;

    // only written beats are stored, the rest come from the fill pattern
    logic [63:0] mem [bit [31:0]];
    int          wait_cnt;
    int          beat_idx;
    logic [31:0] base;

    assign base = {address_i[31:5], 5'b00000};

    function automatic logic [31:0] init_word(input logic [31:0] a);
        return (a ^ 32'h9e37_79b9) ^ {a[20:0], a[31:21]};
    endfunction

    function automatic logic [63:0] read_beat(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {init_word(a + 32'd4), init_word(a)};
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_o   <= 1'b0;
            rdata_o  <= '0;
            wait_cnt <= 0;
            beat_idx <= 0;
        end else begin
            // store the beat shown during the resp cycle just ending
            if (resp_o && write_i) begin
                mem[base + 32'(8 * (beat_idx - 1))] = wdata_i;
            end
            resp_o <= 1'b0;
            if (!read_i && !write_i) begin
                wait_cnt <= 0;
                beat_idx <= 0;
            end else if (wait_cnt < latency_c) begin
                wait_cnt <= wait_cnt + 1;
            end else if (beat_idx < 4) begin
                // four back to back beats
                resp_o   <= 1'b1;
                rdata_o  <= read_beat(base + 32'(8 * beat_idx));
                beat_idx <= beat_idx + 1;
            end
        end
    end

endmodule : burst_mem_model

//--- bench/mem_hier_assertions.sv
module mem_hier_assertions (
    input logic clk,
    input logic rst_n_i,
    input logic req_i,
    input logic resp_i,
    input logic out_read_i,
    input logic out_write_i
);

    // failed assertions in this instance
    int fail_count = 0;

    // resp pulses are one cycle wide
    resp_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) resp_i |=> !resp_i)
    else begin
        fail_count++;
        $error("resp stayed high for more than one cycle");
    end

    // resp only answers a request that is still held
    resp_held: assert property (@(posedge clk) disable iff (!rst_n_i) resp_i |-> req_i)
    else begin
        fail_count++;
        $error("resp without a held request");
    end

    out_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(out_read_i && out_write_i))
    else begin
        fail_count++;
        $error("outgoing read and write high together");
    end

    out_low_in_reset: assert property (@(posedge clk) !rst_n_i |-> !out_read_i && !out_write_i)
    else begin
        fail_count++;
        $error("outgoing request high during reset");
    end

endmodule : mem_hier_assertions

// line side and burst pins of the adaptor
bind cacheline_adaptor mem_hier_assertions cla_checks (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (line_read_i || line_write_i),
    .resp_i      (line_resp_o),
    .out_read_i  (bmem_read_o),
    .out_write_i (bmem_write_o)
);

// fetch port of the arbiter
bind mem_arbiter mem_hier_assertions arb_fetch_checks (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (fetch_read_i),
    .resp_i      (fetch_resp_o),
    .out_read_i  (line_read_o),
    .out_write_i (line_write_o)
);

// data port of the arbiter
bind mem_arbiter mem_hier_assertions arb_data_checks (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (data_read_i || data_write_i),
    .resp_i      (data_resp_o),
    .out_read_i  (line_read_o),
    .out_write_i (line_write_o)
);

//--- bench/tb_mem_hier.sv
module tb_mem_hier
    import mem_hier_pkg::*;
();

    localparam int timeout_cycles = 200;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] imem_address_i;
    logic        imem_read_i;
    logic [31:0] imem_rdata_o;
    logic        imem_resp_o;
    logic [31:0] dmem_address_i;
    logic        dmem_read_i;
    logic        dmem_write_i;
    logic [3:0]  dmem_wmask_i;
    logic [31:0] dmem_wdata_i;
    logic [31:0] dmem_rdata_o;
    logic        dmem_resp_o;
    logic [31:0] bmem_address_o;
    logic        bmem_read_o;
    logic        bmem_write_o;
    logic [63:0] bmem_rdata_i;
    logic [63:0] bmem_wdata_o;
    logic        bmem_resp_i;

    integer      seed;
    int          checks;
    int          mismatches;
    int          timeouts;
    int          assert_fails;
    logic [31:0] imem_exp;
    logic [31:0] dmem_exp;
    logic        dmem_check;

    // bytes stored by the testbench, everything else is still the fill pattern
    logic [7:0]  shadow [bit [31:0]];

    mem_hier_top uut (.*);

    burst_mem_model mem_model (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .address_i (bmem_address_o),
        .read_i    (bmem_read_o),
        .write_i   (bmem_write_o),
        .wdata_i   (bmem_wdata_o),
        .rdata_o   (bmem_rdata_i),
        .resp_o    (bmem_resp_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] init_word(input logic [31:0] a);
        return (a ^ 32'h9e37_79b9) ^ {a[20:0], a[31:21]};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] wa;
        logic [31:0] w;
        wa = {addr[31:2], 2'b00};
        w  = init_word(wa);
        for (int i = 0; i < 4; i++) begin
            if (shadow.exists(wa + i)) begin
                w[8*i +: 8] = shadow[wa + i];
            end
        end
        return w;
    endfunction

    task automatic fetch_read(input logic [31:0] addr, input int skew);
        int   cycles;
        logic got;
        repeat (skew + 1) @(posedge clk);
        #10;
        imem_exp       = expected_word(addr);
        imem_address_i = addr;
        imem_read_i    = 1'b1;
        cycles         = 0;
        got            = 1'b0;
        while (!got && cycles < timeout_cycles) begin
            @(posedge clk);
            got = imem_resp_o;
            cycles++;
        end
        #10;
        imem_read_i = 1'b0;
        if (!got) begin
            $display("Error at time %0t: fetch read of %h got no response in %0d cycles",
                     $time, addr, timeout_cycles);
            timeouts++;
        end
    endtask

    task automatic data_access(input logic is_write, input logic [31:0] addr,
                               input logic [3:0] mask, input logic [31:0] wdata,
                               input int skew);
        int   cycles;
        logic got;
        repeat (skew + 1) @(posedge clk);
        #10;
        if (is_write) begin
            for (int i = 0; i < 4; i++) begin
                if (mask[i]) begin
                    shadow[{addr[31:2], 2'b00} + i] = wdata[8*i +: 8];
                end
            end
        end
        dmem_exp       = expected_word(addr);
        dmem_check     = !is_write;
        dmem_address_i = addr;
        dmem_wmask_i   = mask;
        dmem_wdata_i   = wdata;
        dmem_read_i    = !is_write;
        dmem_write_i   = is_write;
        cycles         = 0;
        got            = 1'b0;
        while (!got && cycles < timeout_cycles) begin
            @(posedge clk);
            got = dmem_resp_o;
            cycles++;
        end
        #10;
        dmem_read_i  = 1'b0;
        dmem_write_i = 1'b0;
        if (!got) begin
            $display("Error at time %0t: data access of %h got no response in %0d cycles",
                     $time, addr, timeout_cycles);
            timeouts++;
        end
    endtask

    // rdata checked in the resp cycle against the value recorded at issue
    always @(posedge clk) begin
        if (rst_n_i && imem_resp_o) begin
            checks++;
            if (imem_rdata_o !== imem_exp) begin
                $display("Mismatch at time %0t: imem_rdata_o got %h expected %h",
                         $time, imem_rdata_o, imem_exp);
                mismatches++;
            end
        end
        if (rst_n_i && dmem_resp_o && dmem_check) begin
            checks++;
            if (dmem_rdata_o !== dmem_exp) begin
                $display("Mismatch at time %0t: dmem_rdata_o got %h expected %h",
                         $time, dmem_rdata_o, dmem_exp);
                mismatches++;
            end
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] faddr;
        logic [31:0] base;
        logic [31:0] data;
        logic [3:0]  mask;
        logic        wr;
        int          fskew;
        int          dskew;
        seed           = 32'h11a8;
        checks         = 0;
        mismatches     = 0;
        timeouts       = 0;
        assert_fails   = 0;
        imem_exp       = '0;
        dmem_exp       = '0;
        dmem_check     = 1'b0;
        imem_address_i = '0;
        imem_read_i    = 1'b0;
        dmem_address_i = '0;
        dmem_read_i    = 1'b0;
        dmem_write_i   = 1'b0;
        dmem_wmask_i   = '0;
        dmem_wdata_i   = '0;
        rst_n_i        = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst_n_i = 1'b1;

        // fill pattern through both ports
        repeat (20) begin
            addr = $random(seed) & 32'hffff_fffc;
            fetch_read(addr, 0);
        end
        repeat (10) begin
            addr = $random(seed) & 32'hffff_fffc;
            data_access(1'b0, addr, 4'h0, 32'h0, 0);
        end
        base = $random(seed) & 32'hffff_ffe0;
        for (int w = 0; w < 8; w++) begin
            data_access(1'b0, base + 4 * w, 4'h0, 32'h0, 0);
        end

        // single byte masks then a full mask, read back on both ports
        addr = base + 32'd12;
        for (int m = 0; m < 5; m++) begin
            mask = (m == 4) ? 4'hf : 4'(1 << m);
            data = $random(seed);
            data_access(1'b1, addr, mask, data, 0);
            data_access(1'b0, addr, 4'h0, 32'h0, 0);
            fetch_read(addr, 0);
        end
        // neighbours of the stored word untouched
        for (int w = 0; w < 8; w++) begin
            data_access(1'b0, base + 4 * w, 4'h0, 32'h0, 0);
        end

        // both ports at once, same cycle or staggered, in a small region
        repeat (300) begin
            addr  = 32'h0000_4000 | ($random(seed) & 32'h0000_03fc);
            faddr = 32'h0000_4000 | ($random(seed) & 32'h0000_03fc);
            data  = $random(seed);
            mask  = 4'($random(seed));
            wr    = 1'($random(seed));
            fskew = $random(seed) & 3;
            dskew = $random(seed) & 3;
            if (mask == 4'h0) begin
                mask = 4'hf;
            end
            // a fetch of the word being stored has no single expected value
            if (wr && faddr[31:2] == addr[31:2]) begin
                faddr = faddr ^ 32'h20;
            end
            fork
                fetch_read(faddr, fskew);
                data_access(wr, addr, mask, data, dskew);
            join
        end

        repeat (2) @(posedge clk);
        assert_fails = uut.cacheline_adaptor.cla_checks.fail_count
                       + uut.mem_arbiter.arb_fetch_checks.fail_count
                       + uut.mem_arbiter.arb_data_checks.fail_count;
        $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 checks, mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0 && checks > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_mem_hier

//--- compile.f
source/mem_hier_pkg.sv
source/mem_word_adapter.sv
source/mem_arbiter.sv
source/cacheline_adaptor.sv
source/mem_hier_top.sv
bench/burst_mem_model.sv
bench/mem_hier_assertions.sv
bench/tb_mem_hier.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := tb_mem_hier
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BUILD_DIR)/V%: $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
